//--- logic/proc_pkg.sv
// Shared word types, address-map bit positions and byte-strobe helper for the memory subsystem
package proc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  wstrb_t;       // All zero means a read
    typedef logic [16:0] fetch_addr_t;  // Byte address bits 18:2

    // Data address map decoded in priority order mem, timer, periph
    localparam int MEM_REGION_BIT    = 30;
    localparam int TIMER_REGION_BIT  = 28;
    localparam int PERIPH_REGION_BIT = 29;

    // Replace the bytes of old_word selected by strb with those of new_word
    function automatic word_t strobe_merge(word_t old_word, word_t new_word, wstrb_t strb);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < $bits(wstrb_t); b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- logic/instr_cache.sv
// Direct-mapped instruction cache with one-word lines, refilled over the controller refill link
`timescale 1ns/1ps

module instr_cache #(
    parameter int ICACHE_LINES = 16
) (
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  proc_pkg::fetch_addr_t fetch_addr_i,
    output proc_pkg::word_t       fetch_data_o,
    output logic                  fetch_wait_o,

    output logic                  refill_valid_o,
    output proc_pkg::fetch_addr_t refill_addr_o,
    input  logic                  refill_ready_i,
    input  proc_pkg::word_t       refill_data_i
);
    localparam int ADDR_BITS  = $bits(proc_pkg::fetch_addr_t);
    localparam int INDEX_BITS = $clog2(ICACHE_LINES);
    localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef enum logic {
        IDLE,
        REFILL
    } state_t;

    state_t                  state_q;
    logic [ICACHE_LINES-1:0] line_valid_q;
    tag_t                    tag_q  [ICACHE_LINES];
    proc_pkg::word_t         data_q [ICACHE_LINES];
    proc_pkg::fetch_addr_t   miss_addr_q;

    index_t fetch_index;
    tag_t   fetch_tag;
    index_t refill_index;
    tag_t   refill_tag;
    logic   hit;

    assign fetch_index  = fetch_addr_i[INDEX_BITS-1:0];
    assign fetch_tag    = fetch_addr_i[ADDR_BITS-1:INDEX_BITS];
    assign refill_index = miss_addr_q[INDEX_BITS-1:0];
    assign refill_tag   = miss_addr_q[ADDR_BITS-1:INDEX_BITS];

    // Lookup is purely combinational so a hit costs no cycle
    assign hit          = line_valid_q[fetch_index] && (tag_q[fetch_index] == fetch_tag);
    assign fetch_data_o = data_q[fetch_index];
    assign fetch_wait_o = !hit;

    assign refill_valid_o = (state_q == REFILL);
    assign refill_addr_o  = miss_addr_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= IDLE;
            line_valid_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (!hit) begin
                        state_q <= REFILL;
                    end
                end
                REFILL: begin
                    if (refill_ready_i) begin
                        state_q                    <= IDLE;
                        line_valid_q[refill_index] <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Line storage and the address of the outstanding miss
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            miss_addr_q <= fetch_addr_i;  // Core holds it while wait is high
        end
        if (state_q == REFILL && refill_ready_i) begin
            tag_q[refill_index]  <= refill_tag;
            data_q[refill_index] <= refill_data_i;
        end
    end

endmodule

//--- logic/data_router.sv
// Decodes core data addresses into target selects and returns read data and stall to the core
`timescale 1ns/1ps

module data_router (
    input  logic            data_sel_i,
    input  proc_pkg::word_t data_addr_i,

    output logic            mem_sel_o,
    output logic            timer_sel_o,
    output logic            pwm_sel_o,

    input  proc_pkg::word_t mem_rdata_i,
    input  proc_pkg::word_t timer_rdata_i,
    input  proc_pkg::word_t pwm_rdata_i,
    input  logic            mem_stall_i,

    output proc_pkg::word_t data_rdata_o,
    output logic            data_stall_o
);
    logic in_mem;
    logic in_timer;
    logic in_pwm;

    // Main memory wins over timer, timer over PWM
    assign in_mem   = data_addr_i[proc_pkg::MEM_REGION_BIT];
    assign in_timer = !in_mem && data_addr_i[proc_pkg::TIMER_REGION_BIT];
    assign in_pwm   = !in_mem && !in_timer && data_addr_i[proc_pkg::PERIPH_REGION_BIT];

    assign mem_sel_o   = data_sel_i && in_mem;
    assign timer_sel_o = data_sel_i && in_timer;
    assign pwm_sel_o   = data_sel_i && in_pwm;

    always_comb begin
        data_rdata_o = '0;    // Unmapped reads as zero
        data_stall_o = 1'b0;  // Only main memory can stall
        if (in_mem) begin
            data_rdata_o = mem_rdata_i;
            data_stall_o = mem_stall_i;
        end else if (in_timer) begin
            data_rdata_o = timer_rdata_i;
        end else if (in_pwm) begin
            data_rdata_o = pwm_rdata_i;
        end
    end

endmodule

//--- logic/mem_controller.sv
// Arbitrates instruction refills and uncached data accesses onto the external valid/ready bus
`timescale 1ns/1ps

module mem_controller (
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  logic                  refill_valid_i,
    input  proc_pkg::fetch_addr_t refill_addr_i,
    output logic                  refill_ready_o,
    output proc_pkg::word_t       refill_data_o,

    input  logic                  data_sel_i,
    input  proc_pkg::word_t       data_addr_i,
    input  proc_pkg::word_t       data_wdata_i,
    input  proc_pkg::wstrb_t      data_wstrb_i,
    output proc_pkg::word_t       data_rdata_o,
    output logic                  data_stall_o,

    output logic                  mem_valid_o,
    input  logic                  mem_ready_i,
    output proc_pkg::wstrb_t      mem_wstrb_o,
    output proc_pkg::word_t       mem_addr_o,
    output proc_pkg::word_t       mem_wdata_o,
    input  proc_pkg::word_t       mem_rdata_i
);
    typedef enum logic [1:0] {
        IDLE,
        BUS_DATA,
        BUS_REFILL,
        DONE
    } state_t;

    state_t          state_q;
    logic            done_data_q;  // DONE cycle belongs to the data port
    proc_pkg::word_t rdata_q;
    logic            data_done;

    assign data_done = (state_q == DONE) && done_data_q;

    assign refill_ready_o = (state_q == DONE) && !done_data_q;
    assign refill_data_o  = rdata_q;
    assign data_rdata_o   = rdata_q;
    assign data_stall_o   = data_sel_i && !data_done;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= IDLE;
            mem_valid_o <= 1'b0;
            done_data_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    // Data access has priority over a pending refill
                    if (data_sel_i) begin
                        state_q     <= BUS_DATA;
                        mem_valid_o <= 1'b1;
                    end else if (refill_valid_i) begin
                        state_q     <= BUS_REFILL;
                        mem_valid_o <= 1'b1;
                    end
                end
                BUS_DATA, BUS_REFILL: begin
                    if (mem_ready_i) begin
                        state_q     <= DONE;
                        mem_valid_o <= 1'b0;
                        done_data_q <= (state_q == BUS_DATA);
                    end
                end
                default: state_q <= IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    // Bus payload is captured at grant and held through the transfer
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            if (data_sel_i) begin
                mem_addr_o  <= data_addr_i;
                mem_wdata_o <= data_wdata_i;
                mem_wstrb_o <= data_wstrb_i;
            end else begin
                mem_addr_o  <= proc_pkg::word_t'({refill_addr_i, 2'b00});
                mem_wdata_o <= '0;
                mem_wstrb_o <= '0;  // Refills are reads
            end
        end
        if (mem_valid_o && mem_ready_i) begin
            rdata_q <= mem_rdata_i;
        end
    end

endmodule

//--- logic/timer_regs.sv
// Timer register block with a loadable free-running counter, a compare register and an IRQ level
`timescale 1ns/1ps

module timer_regs (
    input  logic             clk_i,
    input  logic             reset_i,

    input  logic             sel_i,
    input  proc_pkg::word_t  addr_i,
    input  proc_pkg::word_t  wdata_i,
    input  proc_pkg::wstrb_t wstrb_i,
    output proc_pkg::word_t  rdata_o,

    output logic             irq_o
);
    proc_pkg::word_t count_q;
    proc_pkg::word_t compare_q;
    logic            wr_en;
    logic [1:0]      reg_idx;

    assign wr_en   = sel_i && (wstrb_i != '0);
    assign reg_idx = addr_i[3:2];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q   <= '0;
            compare_q <= '1;
            irq_o     <= 1'b0;
        end else begin
            if (wr_en && reg_idx == 2'd0) begin
                count_q <= proc_pkg::strobe_merge(count_q, wdata_i, wstrb_i);
            end else begin
                count_q <= count_q + 1'b1;
            end
            if (wr_en && reg_idx == 2'd1) begin
                compare_q <= proc_pkg::strobe_merge(compare_q, wdata_i, wstrb_i);
            end
            irq_o <= (count_q >= compare_q);  // Unsigned compare
        end
    end

    always_comb begin
        case (reg_idx)
            2'd0:    rdata_o = count_q;
            2'd1:    rdata_o = compare_q;
            default: rdata_o = '0;
        endcase
    end

endmodule

//--- logic/pwm_unit.sv
// Two-channel PWM peripheral with period and duty registers on the core data bus
`timescale 1ns/1ps

module pwm_unit #(
    parameter int PWM_WIDTH = 16
) (
    input  logic             clk_i,
    input  logic             reset_i,

    input  logic             sel_i,
    input  proc_pkg::word_t  addr_i,
    input  proc_pkg::word_t  wdata_i,
    input  proc_pkg::wstrb_t wstrb_i,
    output proc_pkg::word_t  rdata_o,

    output logic             pwm0_o,
    output logic             pwm1_o
);
    typedef logic [PWM_WIDTH-1:0] pwm_t;

    pwm_t            period_q [2];
    pwm_t            duty_q   [2];
    pwm_t            count_q  [2];
    logic [1:0]      out_q;
    logic            wr_en;
    logic [1:0]      reg_idx;  // Bit 1 picks the channel, bit 0 picks duty
    pwm_t            reg_rd;
    proc_pkg::word_t merged;

    assign wr_en   = sel_i && (wstrb_i != '0);
    assign reg_idx = addr_i[3:2];
    assign reg_rd  = reg_idx[0] ? duty_q[reg_idx[1]] : period_q[reg_idx[1]];
    assign rdata_o = proc_pkg::word_t'(reg_rd);
    assign merged  = proc_pkg::strobe_merge(proc_pkg::word_t'(reg_rd), wdata_i, wstrb_i);

    assign pwm0_o = out_q[0];
    assign pwm1_o = out_q[1];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            period_q <= '{default: '0};
            duty_q   <= '{default: '0};
            count_q  <= '{default: '0};
            out_q    <= '0;
        end else begin
            if (wr_en) begin
                if (reg_idx[0]) begin
                    duty_q[reg_idx[1]] <= merged[PWM_WIDTH-1:0];
                end else begin
                    period_q[reg_idx[1]] <= merged[PWM_WIDTH-1:0];
                end
            end
            for (int ch = 0; ch < 2; ch++) begin
                // Count 0 .. period-1, then wrap
                if (period_q[ch] == '0 || count_q[ch] >= period_q[ch] - 1'b1) begin
                    count_q[ch] <= '0;
                end else begin
                    count_q[ch] <= count_q[ch] + 1'b1;
                end
                out_q[ch] <= (period_q[ch] != '0) && (count_q[ch] < duty_q[ch]);
            end
        end
    end

endmodule

//--- logic/mem_subsystem.sv
// Top level of the memory and peripheral side, connecting cache, router, controller, timer and PWM
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int ICACHE_LINES = 16,
    parameter int PWM_WIDTH    = 16
) (
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  proc_pkg::fetch_addr_t fetch_addr_i,
    output proc_pkg::word_t       fetch_data_o,
    output logic                  fetch_wait_o,

    input  logic                  data_sel_i,
    input  proc_pkg::word_t       data_addr_i,
    input  proc_pkg::word_t       data_wdata_i,
    input  proc_pkg::wstrb_t      data_wstrb_i,
    output proc_pkg::word_t       data_rdata_o,
    output logic                  data_stall_o,

    output logic                  mem_valid_o,
    input  logic                  mem_ready_i,
    output proc_pkg::wstrb_t      mem_wstrb_o,
    output proc_pkg::word_t       mem_addr_o,
    output proc_pkg::word_t       mem_wdata_o,
    input  proc_pkg::word_t       mem_rdata_i,

    output logic                  timer_irq_o,
    output logic                  pwm0_o,
    output logic                  pwm1_o
);
    logic                  refill_valid;
    proc_pkg::fetch_addr_t refill_addr;
    logic                  refill_ready;
    proc_pkg::word_t       refill_data;

    logic                  mem_sel;
    logic                  timer_sel;
    logic                  pwm_sel;
    proc_pkg::word_t       mem_rdata;
    proc_pkg::word_t       timer_rdata;
    proc_pkg::word_t       pwm_rdata;
    logic                  mem_stall;

    instr_cache #(
        .ICACHE_LINES (ICACHE_LINES)
    ) u_instr_cache (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_data_o   (fetch_data_o),
        .fetch_wait_o   (fetch_wait_o),
        .refill_valid_o (refill_valid),
        .refill_addr_o  (refill_addr),
        .refill_ready_i (refill_ready),
        .refill_data_i  (refill_data)
    );

    data_router u_data_router (
        .data_sel_i    (data_sel_i),
        .data_addr_i   (data_addr_i),
        .mem_sel_o     (mem_sel),
        .timer_sel_o   (timer_sel),
        .pwm_sel_o     (pwm_sel),
        .mem_rdata_i   (mem_rdata),
        .timer_rdata_i (timer_rdata),
        .pwm_rdata_i   (pwm_rdata),
        .mem_stall_i   (mem_stall),
        .data_rdata_o  (data_rdata_o),
        .data_stall_o  (data_stall_o)
    );

    mem_controller u_mem_controller (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .refill_valid_i (refill_valid),
        .refill_addr_i  (refill_addr),
        .refill_ready_o (refill_ready),
        .refill_data_o  (refill_data),
        .data_sel_i     (mem_sel),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_wstrb_i   (data_wstrb_i),
        .data_rdata_o   (mem_rdata),
        .data_stall_o   (mem_stall),
        .mem_valid_o    (mem_valid_o),
        .mem_ready_i    (mem_ready_i),
        .mem_wstrb_o    (mem_wstrb_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_rdata_i    (mem_rdata_i)
    );

    timer_regs u_timer_regs (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .sel_i   (timer_sel),
        .addr_i  (data_addr_i),
        .wdata_i (data_wdata_i),
        .wstrb_i (data_wstrb_i),
        .rdata_o (timer_rdata),
        .irq_o   (timer_irq_o)
    );

    pwm_unit #(
        .PWM_WIDTH (PWM_WIDTH)
    ) u_pwm_unit (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .sel_i   (pwm_sel),
        .addr_i  (data_addr_i),
        .wdata_i (data_wdata_i),
        .wstrb_i (data_wstrb_i),
        .rdata_o (pwm_rdata),
        .pwm0_o  (pwm0_o),
        .pwm1_o  (pwm1_o)
    );

endmodule

//--- tests/mem_subsystem_assertions.sv
// Protocol assertions on the memory bus and refill link, bound into mem_controller by the bind below
`timescale 1ns/1ps

module mem_subsystem_assertions (
    input logic             clk_i,
    input logic             reset_i,
    input logic             valid_i,
    input logic             ready_i,
    input proc_pkg::wstrb_t wstrb_i,
    input proc_pkg::word_t  addr_i,
    input proc_pkg::word_t  wdata_i,
    input logic             refill_ready_i
);
    int unsigned fail_count = 0;  // Failed assertions so far

    // Payload frozen until memory takes it
    bus_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_i && !ready_i |=> valid_i && $stable(addr_i) && $stable(wdata_i) && $stable(wstrb_i))
        else begin
            fail_count++;
            $error("memory bus request changed before ready");
        end

    refill_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        refill_ready_i |=> !refill_ready_i)
        else begin
            fail_count++;
            $error("refill ready held longer than one cycle");
        end

    valid_in_reset: assert property (@(posedge clk_i) reset_i |=> !valid_i)
        else begin
            fail_count++;
            $error("memory bus valid high during reset");
        end

endmodule

bind mem_controller mem_subsystem_assertions u_bus_assertions (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .valid_i        (mem_valid_o),
    .ready_i        (mem_ready_i),
    .wstrb_i        (mem_wstrb_o),
    .addr_i         (mem_addr_o),
    .wdata_i        (mem_wdata_o),
    .refill_ready_i (refill_ready_o)
);

//--- tests/tb_mem_subsystem.sv
// Testbench that stands in for the core and checks mem_subsystem when built from flist.f
`timescale 1ns/1ps

module tb_mem_subsystem;
    localparam int          TIMEOUT_CYCLES = 60;
    localparam logic [31:0] MEM_BASE       = 32'd1 << proc_pkg::MEM_REGION_BIT;
    localparam logic [31:0] TIMER_BASE     = 32'd1 << proc_pkg::TIMER_REGION_BIT;
    localparam logic [31:0] PWM_BASE       = 32'd1 << proc_pkg::PERIPH_REGION_BIT;

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    proc_pkg::fetch_addr_t fetch_addr = '0;
    logic                  data_sel = 1'b0;
    proc_pkg::word_t       data_addr = '0;
    proc_pkg::word_t       data_wdata = '0;
    proc_pkg::wstrb_t      data_wstrb = '0;
    logic                  mem_ready = 1'b0;
    proc_pkg::word_t       mem_rdata = '0;
    proc_pkg::word_t       fetch_data;
    logic                  fetch_wait;
    proc_pkg::word_t       data_rdata;
    logic                  data_stall;
    logic                  mem_valid;
    proc_pkg::wstrb_t      mem_wstrb;
    proc_pkg::word_t       mem_addr;
    proc_pkg::word_t       mem_wdata;
    logic                  timer_irq;
    logic                  pwm0;
    logic                  pwm1;

    logic [15:0]     stim_lfsr = 16'd57464;
    logic [15:0]     delay_lfsr = 16'd57464;  // Separate stream for the memory model
    proc_pkg::word_t mem_words [int];         // Memory model holding written entries only
    proc_pkg::word_t ref_words [int];         // Reference copy kept by the stimulus
    logic            bus_busy = 1'b0;
    logic [31:0]     delay_left;
    int              bus_idx;
    proc_pkg::word_t bus_word;
    proc_pkg::word_t ref_compare = '1;
    proc_pkg::word_t ref_period [2];
    proc_pkg::word_t ref_duty [2];

    mem_subsystem #(
        .ICACHE_LINES (16),
        .PWM_WIDTH    (16)
    ) u_mem_subsystem (
        .clk_i        (clk),
        .reset_i      (reset),
        .fetch_addr_i (fetch_addr),
        .fetch_data_o (fetch_data),
        .fetch_wait_o (fetch_wait),
        .data_sel_i   (data_sel),
        .data_addr_i  (data_addr),
        .data_wdata_i (data_wdata),
        .data_wstrb_i (data_wstrb),
        .data_rdata_o (data_rdata),
        .data_stall_o (data_stall),
        .mem_valid_o  (mem_valid),
        .mem_ready_i  (mem_ready),
        .mem_wstrb_o  (mem_wstrb),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata),
        .timer_irq_o  (timer_irq),
        .pwm0_o       (pwm0),
        .pwm1_o       (pwm1)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_bits(inout logic [15:0] state, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            state = {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
            v     = {v[30:0], state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        return lfsr_bits(stim_lfsr, n);
    endfunction

    function automatic proc_pkg::word_t fill_word(input int idx);
        return (32'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;  // Odd multiplier gives a unique word
    endfunction

    function automatic proc_pkg::word_t apply_strobes(input proc_pkg::word_t old_w,
                                                      input proc_pkg::word_t new_w,
                                                      input proc_pkg::wstrb_t strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) old_w[8*b +: 8] = new_w[8*b +: 8];
        end
        return old_w;
    endfunction

    function automatic proc_pkg::word_t ref_word(input int idx);
        return ref_words.exists(idx) ? ref_words[idx] : fill_word(idx);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h",
                                     name, got, exp));
        end
    endtask

    // Stop at the first failed bus protocol assertion
    always @(negedge clk) begin
        if (u_mem_subsystem.u_mem_controller.u_bus_assertions.fail_count != 0) begin
            report_failure("a bus protocol assertion failed");
        end
    end

    // Memory bus model with random ready delay of 0 to 3 cycles
    always @(posedge clk) begin
        if (reset) begin
            mem_ready <= 1'b0;
            bus_busy = 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
        end else if (mem_valid) begin
            if (!bus_busy) begin
                bus_busy   = 1'b1;
                delay_left = lfsr_bits(delay_lfsr, 2);
            end
            if (delay_left == 0) begin
                bus_idx  = int'(mem_addr[18:2]);  // Only bits 18:2 decoded
                bus_word = mem_words.exists(bus_idx) ? mem_words[bus_idx] : fill_word(bus_idx);
                if (mem_wstrb != '0) begin
                    mem_words[bus_idx] = apply_strobes(bus_word, mem_wdata, mem_wstrb);
                end
                mem_rdata <= bus_word;
                mem_ready <= 1'b1;
                bus_busy = 1'b0;
            end else begin
                delay_left = delay_left - 1;
            end
        end
    end

    task automatic data_access(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] strb, output logic [31:0] rdata,
                               output int stalls);
        stalls = 0;
        @(posedge clk);
        data_sel   <= 1'b1;
        data_addr  <= addr;
        data_wdata <= wdata;
        data_wstrb <= strb;
        @(negedge clk);
        while (data_stall) begin
            stalls++;
            if (stalls > TIMEOUT_CYCLES) report_failure("timeout waiting for data_stall_o to fall");
            @(negedge clk);
        end
        rdata = data_rdata;
        @(posedge clk);
        data_sel   <= 1'b0;
        data_wstrb <= '0;
    endtask

    task automatic fetch_word(input proc_pkg::fetch_addr_t addr, input logic check_hit);
        int waited;
        waited = 0;
        @(posedge clk);
        fetch_addr <= addr;
        @(negedge clk);
        while (fetch_wait) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) report_failure("timeout waiting for fetch_wait_o to fall");
            @(negedge clk);
        end
        check_value("fetch_data_o", fetch_data, ref_word(int'(addr)));
        if (check_hit) begin
            @(negedge clk);  // Same address again must hit
            check_value("fetch_wait_o", 32'(fetch_wait), 32'd0);
            check_value("fetch_data_o", fetch_data, ref_word(int'(addr)));
        end
    endtask

    // Optional strobed write to main memory and a read back against the reference
    task automatic mem_op();
        int          idx;
        int          stalls;
        logic [31:0] addr, wdata, rd;
        logic [3:0]  strb;
        idx   = 32'h100 | int'(stim_bits(8));
        addr  = MEM_BASE | (32'(idx) << 2);
        wdata = stim_bits(32);
        strb  = 4'(stim_bits(4));
        if (strb != 4'h0) begin
            data_access(addr, wdata, strb, rd, stalls);
            ref_words[idx] = apply_strobes(ref_word(idx), wdata, strb);
        end
        data_access(addr, 32'h0, 4'h0, rd, stalls);
        check_value("data_rdata_o", rd, ref_word(idx));
        check_value("mem stall at least 2", 32'(stalls >= 2), 32'd1);
    endtask

    initial begin
        logic [31:0]           rd, wdata, load;
        logic [3:0]            strb;
        int                    stalls, waited, highs;
        proc_pkg::fetch_addr_t faddr;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        fetch_word('0, 1'b0);
        repeat (30) fetch_word(proc_pkg::fetch_addr_t'(stim_bits(8)), 1'b1);
        repeat (40) mem_op();
        repeat (20) begin
            faddr = proc_pkg::fetch_addr_t'(stim_bits(8));
            fork
                fetch_word(faddr, 1'b0);
                mem_op();
            join
        end

        // Compare between 0x8000_0000 and 0xBFFF_FFFF keeps the counter below it and clear of wrap
        wdata = (stim_bits(32) & 32'h3FFF_FFFF) | 32'h8000_0000;
        strb  = 4'(stim_bits(4)) | 4'h8;
        ref_compare = apply_strobes(ref_compare, wdata, strb);
        data_access(TIMER_BASE + 32'd4, wdata, strb, rd, stalls);
        check_value("timer stall cycles", 32'(stalls), 32'd0);
        data_access(TIMER_BASE + 32'd4, 32'h0, 4'h0, rd, stalls);
        check_value("timer compare", rd, ref_compare);
        load = ref_compare - 32'd1 - stim_bits(4);
        data_access(TIMER_BASE, load, 4'hF, rd, stalls);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) report_failure("timeout waiting for timer_irq_o to rise");
        end while (!timer_irq);
        data_access(TIMER_BASE, 32'h0, 4'h0, rd, stalls);
        check_value("timer count not below load", 32'(rd >= load), 32'd1);

        for (int round = 0; round < 3; round++) begin
            for (int ch = 0; ch < 2; ch++) begin
                ref_period[ch] = 32'd1 + stim_bits(6);
                ref_duty[ch]   = stim_bits(7);
                data_access(PWM_BASE + 32'(8 * ch), ref_period[ch], 4'hF, rd, stalls);
                data_access(PWM_BASE + 32'(8 * ch + 4), ref_duty[ch], 4'hF, rd, stalls);
            end
            for (int ch = 0; ch < 2; ch++) begin
                data_access(PWM_BASE + 32'(8 * ch), 32'h0, 4'h0, rd, stalls);
                check_value("pwm period", rd, ref_period[ch]);
                data_access(PWM_BASE + 32'(8 * ch + 4), 32'h0, 4'h0, rd, stalls);
                check_value("pwm duty", rd, ref_duty[ch]);
            end
            for (int ch = 0; ch < 2; ch++) begin
                highs = 0;
                repeat (ref_period[ch]) begin
                    @(negedge clk);
                    highs += (ch == 0) ? pwm0 : pwm1;
                end
                check_value(ch == 0 ? "pwm0_o high cycles" : "pwm1_o high cycles", 32'(highs),
                            (ref_duty[ch] < ref_period[ch]) ? ref_duty[ch] : ref_period[ch]);
            end
        end

        repeat (5) begin
            wdata = stim_bits(32);
            strb  = 4'(stim_bits(4));
            data_access(stim_bits(32) & ~(MEM_BASE | TIMER_BASE | PWM_BASE), wdata, strb,
                        rd, stalls);
            check_value("unmapped data_rdata_o", rd, 32'h0);
            check_value("unmapped stall cycles", 32'(stalls), 32'd0);
        end

        for (int idx = 32'h100; idx < 32'h200; idx++) begin
            check_value("memory word", mem_words.exists(idx) ? mem_words[idx] : fill_word(idx),
                        ref_word(idx));
        end

        if (u_mem_subsystem.u_mem_controller.u_bus_assertions.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_failure("bus protocol assertions failed during the run");
        end
    end

endmodule

//--- flist.f
logic/proc_pkg.sv
logic/instr_cache.sv
logic/data_router.sv
logic/mem_controller.sv
logic/timer_regs.sv
logic/pwm_unit.sv
logic/mem_subsystem.sv
tests/mem_subsystem_assertions.sv
tests/tb_mem_subsystem.sv
